/* common/spiPkg.sv */
// shared definitions for the SPI slave register bridge
// opcode and controller state enums, frame field widths, register map constants

package spiPkg;

	// --------------------
	// frame fields
	// --------------------
	// USI bus data and address width
	localparam int usiWidth = 32;
	// opcode field length
	localparam int cmdBits = 8;
	// opcode + address + data
	localparam int frameBits = cmdBits + 2 * usiWidth;
	// bit counter width, 72 bits need 7
	localparam int cntBits = $clog2(frameBits);
	// last bit index of each field, counted from zero
	localparam int cmdLast = cmdBits - 1;
	localparam int adrsLast = cmdBits + usiWidth - 1;
	localparam int dataLast = frameBits - 1;

	// --------------------
	// register map
	// --------------------
	localparam int csrWords = 16;
	localparam int csrIdxBits = $clog2(csrWords);
	// word 0 contents, read only
	localparam logic [usiWidth-1:0] csrIdValue = 32'h5350_4901;

	// command byte, anything else is ignored
	typedef enum logic [cmdBits-1:0] {
		opWrite = 8'h02,
		opRead  = 8'h03
	} spiOpcode;

	// frame controller states
	typedef enum logic [2:0] {
		stIdle,
		stCmd,
		stAdrs,
		stData,
		stSkip
	} frameState;

endpackage

/* spi/spiShifter.sv */
// SPI pin side of the slave
// two-flop pin synchronizers, sck edge detect in the sclk domain
// mosi shift-in register and miso shift-out register, mode 0, MSB first

`timescale 1ns/1ps

module spiShifter import spiPkg::*; (
	input  logic                sclk,
	input  logic                rst,
	// SPI pins
	input  logic                csn,
	input  logic                sck,
	input  logic                mosi,
	output logic                miso,
	// edge pulses and frame level
	output logic                sckRise,
	output logic                sckFall,
	output logic                csActive,
	// serial words
	output logic [usiWidth-1:0] rxWord,
	input  logic [usiWidth-1:0] txWord,
	input  logic                txLoad
);

	// --------------------
	// pin synchronizers
	// --------------------
	logic [1:0] csnSync;
	logic [1:0] sckSync;
	logic [1:0] mosiSync;
	// previous synchronized sck for edge compare
	logic sckPrev;
	logic [usiWidth-1:0] txShift;

	always_ff @(posedge sclk) begin
		if (rst) begin
			// idle pin levels, csn high and sck low
			csnSync  <= 2'b11;
			sckSync  <= 2'b00;
			mosiSync <= 2'b00;
			sckPrev  <= 1'b0;
			sckRise  <= 1'b0;
			sckFall  <= 1'b0;
			csActive <= 1'b0;
		end else begin
			csnSync  <= {csnSync[0], csn};
			sckSync  <= {sckSync[0], sck};
			mosiSync <= {mosiSync[0], mosi};
			sckPrev  <= sckSync[1];
			// third stage, edge pulses registered
			sckRise  <= sckSync[1] & ~sckPrev;
			sckFall  <= ~sckSync[1] & sckPrev;
			csActive <= ~csnSync[1];
		end
	end

	// --------------------
	// receive side
	// --------------------
	// mosi stable around the rise, master moves it on the fall
	always_ff @(posedge sclk) begin
		if (sckRise) begin
			rxWord <= {rxWord[usiWidth-2:0], mosiSync[1]};
		end
	end

	// --------------------
	// transmit side
	// --------------------
	// cleared between frames so miso rests low
	always_ff @(posedge sclk) begin
		if (rst || !csActive) begin
			txShift <= '0;
		end else if (txLoad) begin
			txShift <= txWord;
		end else if (sckFall) begin
			txShift <= {txShift[usiWidth-2:0], 1'b0};
		end
	end

	// MSB first
	assign miso = txShift[usiWidth-1];

endmodule

/* spi/spiFrameCtrl.sv */
// frame controller for the SPI slave
// bit counter and FSM marking opcode, address and data boundaries
// opcode decode, unknown commands skip to end of frame

`timescale 1ns/1ps

module spiFrameCtrl import spiPkg::*; (
	input  logic               sclk,
	input  logic               rst,
	input  logic               sckRise,
	input  logic               csActive,
	input  logic [cmdBits-1:0] rxByte,
	output logic               cmdDone,
	output logic               adrsDone,
	output logic               dataDone,
	output logic               isRead
);

	frameState state;
	logic [cntBits-1:0] bitCnt;
	spiOpcode opcode;

	// command byte as seen in the cmdDone cycle
	assign opcode = spiOpcode'(rxByte);

	always_ff @(posedge sclk) begin
		if (rst) begin
			state    <= stIdle;
			bitCnt   <= '0;
			cmdDone  <= 1'b0;
			adrsDone <= 1'b0;
			dataDone <= 1'b0;
			isRead   <= 1'b0;
		end else begin
			// strobes last one cycle
			cmdDone  <= 1'b0;
			adrsDone <= 1'b0;
			dataDone <= 1'b0;
			if (!csActive) begin
				// csn high ends or aborts the frame, no strobe
				state  <= stIdle;
				bitCnt <= '0;
				isRead <= 1'b0;
			end else begin
				// count only while fields are still being received
				if (sckRise && (state == stCmd || state == stAdrs || state == stData)) begin
					bitCnt <= bitCnt + 1'b1;
				end
				unique case (state)
					stIdle: begin
						state <= stCmd;
					end
					// --------------------
					// opcode field
					// --------------------
					stCmd: begin
						if (cmdDone) begin
							// decode once the 8th bit sits in rxByte
							unique case (opcode)
								opWrite: begin
									state  <= stAdrs;
									isRead <= 1'b0;
								end
								opRead: begin
									state  <= stAdrs;
									isRead <= 1'b1;
								end
								default: state <= stSkip;
							endcase
						end else if (sckRise && bitCnt == cntBits'(cmdLast)) begin
							cmdDone <= 1'b1;
						end
					end
					// address field
					stAdrs: begin
						if (sckRise && bitCnt == cntBits'(adrsLast)) begin
							adrsDone <= 1'b1;
							state    <= stData;
						end
					end
					// data field, strobe for writes only
					stData: begin
						if (sckRise && bitCnt == cntBits'(dataLast)) begin
							dataDone <= ~isRead;
							state    <= stSkip;
						end
					end
					// wait for csn to rise
					stSkip: begin
						state <= stSkip;
					end
					default: state <= stIdle;
				endcase
			end
		end
	end

endmodule

/* source/spiUsibBridge.sv */
// bridge between the SPI frame side and the USI register bus
// address latch, write data pass-through, write/read strobes
// read data return with the shift-out load strobe

`timescale 1ns/1ps

module spiUsibBridge import spiPkg::*; (
	input  logic                sclk,
	input  logic                rst,
	// frame side
	input  logic                adrsDone,
	input  logic                dataDone,
	input  logic                isRead,
	input  logic [usiWidth-1:0] rxWord,
	// USI bus
	output logic [usiWidth-1:0] usiAdrs,
	output logic [usiWidth-1:0] usiWd,
	output logic                usiWe,
	output logic                usiRe,
	input  logic [usiWidth-1:0] usiRd,
	// back to the shifter
	output logic [usiWidth-1:0] txWord,
	output logic                txLoad
);

	// --------------------
	// address and data
	// --------------------
	// hold the address while the shift register moves on to the data field
	always_ff @(posedge sclk) begin
		if (adrsDone) begin
			usiAdrs <= rxWord;
		end
	end

	// data field still sits in rxWord when usiWe fires
	assign usiWd = rxWord;

	// --------------------
	// strobes
	// --------------------
	always_ff @(posedge sclk) begin
		if (rst) begin
			usiWe  <= 1'b0;
			usiRe  <= 1'b0;
			txLoad <= 1'b0;
		end else begin
			// read right after the address, write after the data
			usiRe  <= adrsDone & isRead;
			usiWe  <= dataDone;
			// usiRd is registered one cycle after usiRe
			txLoad <= usiRe;
		end
	end

	// csr read data goes back as is
	assign txWord = usiRd;

endmodule

/* source/csrRegFile.sv */
// control and status register bank on the USI bus
// 16 words, word 0 read-only ID, unmapped reads return zero

`timescale 1ns/1ps

module csrRegFile import spiPkg::*; (
	input  logic                sclk,
	input  logic                rst,
	input  logic [usiWidth-1:0] usiAdrs,
	input  logic [usiWidth-1:0] usiWd,
	input  logic                usiWe,
	input  logic                usiRe,
	output logic [usiWidth-1:0] usiRd
);

	logic [usiWidth-1:0] csrMem [csrWords];
	logic [csrIdxBits-1:0] wordIdx;
	logic mapped;

	// --------------------
	// address decode
	// --------------------
	// word index from bits 5:2
	assign wordIdx = usiAdrs[csrIdxBits+1:2];
	// any other set bit falls outside the bank
	assign mapped = (usiAdrs[usiWidth-1:csrIdxBits+2] == '0) && (usiAdrs[1:0] == 2'b00);

	// --------------------
	// register bank
	// --------------------
	always_ff @(posedge sclk) begin
		if (rst) begin
			// ID in word 0, control words cleared
			csrMem[0] <= csrIdValue;
			for (int i = 1; i < csrWords; i++) begin
				csrMem[i] <= '0;
			end
		end else if (usiWe && mapped && wordIdx != '0) begin
			csrMem[wordIdx] <= usiWd;
		end
	end

	// registered read, valid the cycle after usiRe
	always_ff @(posedge sclk) begin
		if (usiRe) begin
			usiRd <= mapped ? csrMem[wordIdx] : '0;
		end
	end

endmodule

/* source/spiUsibTop.sv */
// SPI slave register subsystem, top level
// shifter, frame controller, USI bridge and register bank

`timescale 1ns/1ps

module spiUsibTop import spiPkg::*; (
	input  logic sclk,
	input  logic rst,
	input  logic csn,
	input  logic sck,
	input  logic mosi,
	output logic miso
);

	// shifter outputs
	logic sckRise;
	logic sckFall;
	logic csActive;
	logic [usiWidth-1:0] rxWord;
	// frame strobes
	logic cmdDone;
	logic adrsDone;
	logic dataDone;
	logic isRead;
	// USI bus
	logic [usiWidth-1:0] usiAdrs;
	logic [usiWidth-1:0] usiWd;
	logic usiWe;
	logic usiRe;
	logic [usiWidth-1:0] usiRd;
	// read return
	logic [usiWidth-1:0] txWord;
	logic txLoad;

	spiShifter spiShifter_inst (
		.sclk     (sclk),
		.rst      (rst),
		.csn      (csn),
		.sck      (sck),
		.mosi     (mosi),
		.miso     (miso),
		.sckRise  (sckRise),
		.sckFall  (sckFall),
		.csActive (csActive),
		.rxWord   (rxWord),
		.txWord   (txWord),
		.txLoad   (txLoad)
	);

	// opcode is the low byte of the shift register
	spiFrameCtrl spiFrameCtrl_inst (
		.sclk     (sclk),
		.rst      (rst),
		.sckRise  (sckRise),
		.csActive (csActive),
		.rxByte   (rxWord[cmdBits-1:0]),
		.cmdDone  (cmdDone),
		.adrsDone (adrsDone),
		.dataDone (dataDone),
		.isRead   (isRead)
	);

	spiUsibBridge spiUsibBridge_inst (
		.sclk     (sclk),
		.rst      (rst),
		.adrsDone (adrsDone),
		.dataDone (dataDone),
		.isRead   (isRead),
		.rxWord   (rxWord),
		.usiAdrs  (usiAdrs),
		.usiWd    (usiWd),
		.usiWe    (usiWe),
		.usiRe    (usiRe),
		.usiRd    (usiRd),
		.txWord   (txWord),
		.txLoad   (txLoad)
	);

	csrRegFile csrRegFile_inst (
		.sclk    (sclk),
		.rst     (rst),
		.usiAdrs (usiAdrs),
		.usiWd   (usiWd),
		.usiWe   (usiWe),
		.usiRe   (usiRe),
		.usiRd   (usiRd)
	);

endmodule

/* dv/spiUsib_props.sv */
// strobe properties for the bridge and the frame controller
// bound into both blocks with their own strobe hookup

`timescale 1ns/1ps

module spiUsibProps (
	input logic sclk,
	input logic rst,
	input logic pulseA,
	input logic pulseB,
	input logic pulseC,
	input logic wrPulse,
	input logic rdLevel
);

	int propFails = 0;

	property singleCycle(sig);
		@(posedge sclk) disable iff (rst) sig |=> !sig;
	endproperty

	// --------------------
	// strobe widths
	// --------------------
	pulseAWidth: assert property (singleCycle(pulseA)) else begin
		$error("strobe A held for more than one cycle");
		propFails++;
	end
	pulseBWidth: assert property (singleCycle(pulseB)) else begin
		$error("strobe B held for more than one cycle");
		propFails++;
	end
	pulseCWidth: assert property (singleCycle(pulseC)) else begin
		$error("strobe C held for more than one cycle");
		propFails++;
	end

	// write and read side never at once
	exclusive: assert property (@(posedge sclk) disable iff (rst) !(pulseA && pulseB)) else begin
		$error("strobes A and B high together");
		propFails++;
	end
	noWriteOnRead: assert property (@(posedge sclk) disable iff (rst) !(wrPulse && rdLevel))
		else begin
		$error("write strobe during a read frame");
		propFails++;
	end

endmodule

// usiWe/usiRe exclusive, txLoad single cycle
bind spiUsibBridge spiUsibProps bridgeProps (
	.sclk    (sclk),
	.rst     (rst),
	.pulseA  (usiWe),
	.pulseB  (usiRe),
	.pulseC  (txLoad),
	.wrPulse (usiWe),
	.rdLevel (isRead)
);

// field strobes, no dataDone on reads
bind spiFrameCtrl spiUsibProps ctrlProps (
	.sclk    (sclk),
	.rst     (rst),
	.pulseA  (adrsDone),
	.pulseB  (dataDone),
	.pulseC  (cmdDone),
	.wrPulse (dataDone),
	.rdLevel (isRead)
);

/* dv/spiUsibTb.sv */
// testbench for the SPI slave register subsystem
// clock, reset, LFSR, SPI master tasks, register model
// compare tasks, cycle timeout and test summary

`timescale 1ns/1ps

module spiUsibTb import spiPkg::*; ();

	// sck half period in sclk cycles
	localparam int halfPeriod = 10;
	localparam int nMapped = 12;
	localparam int nUnmapped = 6;
	localparam int nUnknown = 6;
	localparam int nAbort = 4;
	// frames sent by all tests together
	localparam int frameCount = 2 * nMapped + 3 + 2 * nUnmapped + (csrWords - 1)
		+ nUnknown + (csrWords - 1) + 4 * nAbort;
	// two half periods per bit, plus csn setup, hold and gap per frame
	localparam int timeoutCycles = frameCount * (frameBits * 2 * halfPeriod + 8 * halfPeriod)
		+ 1000;

	logic sclk;
	logic rst;
	logic csn;
	logic sck;
	logic mosi;
	logic miso;

	logic [31:0] lfsrState = 32'h4ef5_3b62;
	logic [usiWidth-1:0] model [csrWords];
	int cycleCnt = 0;
	int errors = 0;
	int checks = 0;
	int testNum = 0;
	int testErrStart = 0;

	spiUsibTop spiUsibTop_inst (
		.sclk (sclk),
		.rst  (rst),
		.csn  (csn),
		.sck  (sck),
		.mosi (mosi),
		.miso (miso)
	);

	initial begin
		sclk = 1'b0;
		forever #5 sclk = ~sclk;
	end

	// run limit
	always @(posedge sclk) begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= timeoutCycles) begin
			$display("timeout: run did not finish within %0d cycles", timeoutCycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// --------------------
	// random numbers
	// --------------------
	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one LFSR step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			val = {val[30:0], lfsrState[0]};
		end
		return val;
	endfunction

	// --------------------
	// register model
	// --------------------
	// index in bits 5:2, every other bit must be zero
	function automatic logic isMapped(input logic [usiWidth-1:0] a);
		return (a & ~32'h0000_003c) == '0;
	endfunction

	function automatic logic [usiWidth-1:0] modelRead(input logic [usiWidth-1:0] a);
		return isMapped(a) ? model[a[5:2]] : '0;
	endfunction

	function automatic logic [usiWidth-1:0] wordAdrs(input logic [3:0] idx);
		return {{(usiWidth - 6){1'b0}}, idx, 2'b00};
	endfunction

	// random word index 1 to 15
	function automatic logic [3:0] randIdx();
		logic [31:0] r;
		r = randBits(4);
		return (r[3:0] == 4'd0) ? 4'd15 : r[3:0];
	endfunction

	// --------------------
	// compare tasks
	// --------------------
	task automatic checkWord(input logic [usiWidth-1:0] got, input logic [usiWidth-1:0] exp,
			input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR [%0t] %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkIdle(input logic lvl, input string what);
		checks++;
		if (lvl !== 1'b0) begin
			errors++;
			$display("ERROR [%0t] %s: miso is %b, expected 0", $time, what, lvl);
		end
	endtask

	// --------------------
	// SPI master
	// --------------------
	// inputs change 1 ns after the sclk edge
	task automatic waitCycles(input int n);
		repeat (n) @(posedge sclk);
		#1;
	endtask

	// mode 0 frame, csn raised after stopAt bits
	task automatic sendFrame(input logic [cmdBits-1:0] op, input logic [usiWidth-1:0] adrs,
			input logic [usiWidth-1:0] data, input int stopAt,
			output logic [usiWidth-1:0] rdWord, output logic misoAny);
		logic [frameBits-1:0] bits;
		bits = {op, adrs, data};
		rdWord = '0;
		misoAny = 1'b0;
		csn = 1'b0;
		waitCycles(halfPeriod);
		for (int i = 0; i < stopAt; i++) begin
			mosi = bits[frameBits-1-i];
			waitCycles(halfPeriod);
			sck = 1'b1;
			waitCycles(halfPeriod);
			misoAny = misoAny | miso;
			// read data appears during the last address clock, bit 31 first
			if (i >= adrsLast && i < dataLast) begin
				rdWord = {rdWord[usiWidth-2:0], miso};
			end
			sck = 1'b0;
		end
		waitCycles(halfPeriod);
		csn = 1'b1;
		mosi = 1'b0;
		waitCycles(2 * halfPeriod);
		checkIdle(miso, "miso between frames");
	endtask

	task automatic writeWord(input logic [usiWidth-1:0] a, input logic [usiWidth-1:0] d);
		logic [usiWidth-1:0] rd;
		logic any;
		sendFrame(opWrite, a, d, frameBits, rd, any);
		// word 0 and unmapped addresses ignore writes
		if (isMapped(a) && a[5:2] != 4'd0) begin
			model[a[5:2]] = d;
		end
	endtask

	task automatic readWord(input logic [usiWidth-1:0] a, output logic [usiWidth-1:0] d);
		logic any;
		sendFrame(opRead, a, '0, frameBits, d, any);
	endtask

	task automatic checkRead(input logic [usiWidth-1:0] a, input string what);
		logic [usiWidth-1:0] got;
		readWord(a, got);
		checkWord(got, modelRead(a), what);
	endtask

	task automatic checkAll();
		for (int i = 1; i < csrWords; i++) begin
			checkRead(wordAdrs(4'(i)), $sformatf("word %0d readback", i));
		end
	endtask

	task automatic finishTest(input string name);
		testNum++;
		$display("test %0d %s: %s, %0d errors", testNum, name,
			(errors == testErrStart) ? "ok" : "failed", errors - testErrStart);
		testErrStart = errors;
	endtask

	// --------------------
	// tests
	// --------------------
	initial begin
		logic [31:0] r;
		logic [usiWidth-1:0] a;
		logic [usiWidth-1:0] got;
		logic [cmdBits-1:0] op;
		logic any;
		int stopAt;
		rst = 1'b1;
		csn = 1'b1;
		sck = 1'b0;
		mosi = 1'b0;
		for (int i = 0; i < csrWords; i++) begin
			model[i] = '0;
		end
		model[0] = csrIdValue;
		repeat (5) @(posedge sclk);
		#1;
		rst = 1'b0;
		waitCycles(4);
		checkIdle(miso, "miso after reset");

		// random mapped writes with readback
		for (int k = 0; k < nMapped; k++) begin
			a = wordAdrs(randIdx());
			writeWord(a, randBits(usiWidth));
			checkRead(a, "mapped word readback");
		end
		finishTest("mapped writes");

		// ID word, read only
		readWord(wordAdrs(4'd0), got);
		checkWord(got, csrIdValue, "ID word read");
		writeWord(wordAdrs(4'd0), randBits(usiWidth));
		readWord(wordAdrs(4'd0), got);
		checkWord(got, csrIdValue, "ID word after write");
		finishTest("ID word");

		// unmapped addresses read zero
		for (int k = 0; k < nUnmapped; k++) begin
			a = randBits(usiWidth);
			if (isMapped(a)) begin
				a[31] = 1'b1;
			end
			writeWord(a, randBits(usiWidth));
			checkRead(a, "unmapped read");
		end
		checkAll();
		finishTest("unmapped addresses");

		// unknown opcodes, no change and miso quiet
		for (int k = 0; k < nUnknown; k++) begin
			r = randBits(cmdBits);
			op = r[cmdBits-1:0];
			while (op == opWrite || op == opRead) begin
				r = randBits(cmdBits);
				op = r[cmdBits-1:0];
			end
			sendFrame(op, wordAdrs(randIdx()), randBits(usiWidth), frameBits, got, any);
			checkIdle(any, "miso during unknown opcode frame");
		end
		checkAll();
		finishTest("unknown opcodes");

		// aborted writes, then a normal write
		for (int k = 0; k < nAbort; k++) begin
			a = wordAdrs(randIdx());
			r = randBits(7);
			stopAt = 1 + int'(r[6:0]) % (frameBits - 1);
			sendFrame(opWrite, a, randBits(usiWidth), stopAt, got, any);
			checkRead(a, "word after aborted write");
			writeWord(a, randBits(usiWidth));
			checkRead(a, "write after abort");
		end
		finishTest("aborted writes");

		errors += spiUsibTop_inst.spiUsibBridge_inst.bridgeProps.propFails;
		errors += spiUsibTop_inst.spiFrameCtrl_inst.ctrlProps.propFails;
		$display("tests: %0d, checks: %0d, errors: %0d", testNum, checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* filelist.f */
common/spiPkg.sv
spi/spiShifter.sv
spi/spiFrameCtrl.sv
source/spiUsibBridge.sv
source/csrRegFile.sv
source/spiUsibTop.sv
dv/spiUsib_props.sv
dv/spiUsibTb.sv

/* Bender.yml */
package:
  name: spi_usib

sources:
  - common/spiPkg.sv
  - spi/spiShifter.sv
  - spi/spiFrameCtrl.sv
  - source/spiUsibBridge.sv
  - source/csrRegFile.sv
  - source/spiUsibTop.sv
  - target: test
    files:
      - dv/spiUsib_props.sv
      - dv/spiUsibTb.sv
